/* duck_pkg.sv */
// shared geometry, timing, color and type definitions that the duck-hunt core references by scope

package duck_pkg;

    // ------------------------------------------------------------
    // types
    // ------------------------------------------------------------
    typedef logic [11:0] pos_t;    // whole pixel coordinate
    typedef logic [35:0] pos_q_t;  // q12.24 coordinate
    typedef logic [9:0]  rnd_t;    // random launch number
    typedef logic [11:0] rgb_t;    // 4 bits per channel in r g b order
    typedef logic [7:0]  score_t;  // hit counter

    // duck flight states
    typedef enum logic [2:0] {
        IDLE       = 3'd0,
        SIDE       = 3'd1,
        UP_RIGHT   = 3'd2,
        UP_LEFT    = 3'd3,
        DOWN_RIGHT = 3'd4,
        DOWN_LEFT  = 3'd5
    } flight_t;

    // ------------------------------------------------------------
    // raster timing of the 1024x768 frame
    // ------------------------------------------------------------
    localparam int H_ACTIVE = 1024;  // visible pixels per line
    localparam int H_FP     = 24;    // front porch
    localparam int H_SYNC   = 136;   // sync pulse width
    localparam int H_TOTAL  = 1344;  // full line incl. back porch

    localparam int V_ACTIVE = 768;   // visible lines
    localparam int V_FP     = 3;
    localparam int V_SYNC   = 6;
    localparam int V_TOTAL  = 806;

    // ------------------------------------------------------------
    // playfield and duck geometry
    // ------------------------------------------------------------
    localparam int X_MAX       = 1024;  // right limit of the flight area
    localparam int DUCK_WIDTH  = 96;
    localparam int DUCK_HEIGHT = 32;
    localparam int GROUND      = 620;   // lowest y and also the rest row
    localparam int IDLE_X      = 512;   // rest column

    // default flight step in q12.24 units per clock
    localparam int DUCK_SPEED_DEF = 627;

    // misc
    localparam rnd_t LFSR_SEED = 10'h001;  // any nonzero value works
    localparam rgb_t DUCK_RGB  = 12'hA52;  // brownish duck
    localparam rgb_t SKY_RGB   = 12'h6CF;  // light blue background

endpackage

/* lfsr_gen.sv */
// 10-bit fibonacci LFSR, feeds a fresh pseudo-random launch column to the duck FSM every clock
`timescale 1ns/100ps

module lfsr_gen (
    input  logic           clk,
    input  logic           rst,
    output duck_pkg::rnd_t rnd
);

    duck_pkg::rnd_t lfsr;
    logic           fb;  // feedback bit

    assign fb  = lfsr[9] ^ lfsr[6];  // x^10 + x^7 + 1, maximal length
    assign rnd = lfsr;

    always_ff @(posedge clk) begin : lfsr_blk
        if (rst) begin
            lfsr <= duck_pkg::LFSR_SEED;
        end else begin
            lfsr <= {lfsr[8:0], fb};  // shift left, feedback into bit 0
        end
    end

    // all-zero is the lock-up state of an xor LFSR
    // a nonzero seed and maximal taps must keep us out of it forever
    a_lfsr_nonzero : assert property (
        @(posedge clk) disable iff (rst)
        lfsr != '0
    ) else $error("lfsr reached the all-zero lock-up state");

endmodule

/* vga_timing.sv */
// free-running raster counters with sync and blanking decode for the 1024x768 frame
`timescale 1ns/100ps

module vga_timing (
    input  logic           clk,
    input  logic           rst,
    output duck_pkg::pos_t hcount,
    output duck_pkg::pos_t vcount,
    output logic           hsync_raw,
    output logic           vsync_raw,
    output logic           blank
);

    logic h_last;  // last pixel of the line
    logic v_last;  // last line of the frame

    assign h_last = (hcount == duck_pkg::pos_t'(duck_pkg::H_TOTAL - 1));
    assign v_last = (vcount == duck_pkg::pos_t'(duck_pkg::V_TOTAL - 1));

    // ------------------------------------------------------------
    // counters
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin : hcnt_blk
        if (rst) begin
            hcount <= '0;
        end else if (h_last) begin
            hcount <= '0;  // wrap at end of line
        end else begin
            hcount <= hcount + 1'b1;
        end
    end

    always_ff @(posedge clk) begin : vcnt_blk
        if (rst) begin
            vcount <= '0;
        end else if (h_last) begin  // one line per horizontal wrap
            if (v_last) begin
                vcount <= '0;
            end else begin
                vcount <= vcount + 1'b1;
            end
        end
    end

    // ------------------------------------------------------------
    // sync and blank decode, straight from the counts
    // ------------------------------------------------------------
    always_comb begin : decode_blk
        // active low sync pulses
        hsync_raw = !((hcount >= duck_pkg::H_ACTIVE + duck_pkg::H_FP) &&
                      (hcount <  duck_pkg::H_ACTIVE + duck_pkg::H_FP + duck_pkg::H_SYNC));
        vsync_raw = !((vcount >= duck_pkg::V_ACTIVE + duck_pkg::V_FP) &&
                      (vcount <  duck_pkg::V_ACTIVE + duck_pkg::V_FP + duck_pkg::V_SYNC));

        // high anywhere outside the visible area
        blank = (hcount >= duck_pkg::H_ACTIVE) || (vcount >= duck_pkg::V_ACTIVE);
    end

endmodule

/* duck_ctl.sv */
// duck flight FSM, q12.24 position that bounces off the edges and the ground and rests on kill
`timescale 1ns/100ps

module duck_ctl #(
    parameter duck_pkg::pos_q_t speed = duck_pkg::DUCK_SPEED_DEF  // step per clock, q12.24
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           game_enable,
    input  logic           kill,
    input  duck_pkg::rnd_t rnd,
    output duck_pkg::pos_t xpos,
    output duck_pkg::pos_t ypos
);

    duck_pkg::flight_t state, state_nxt;
    duck_pkg::pos_q_t  x_q, y_q;          // current position, q12.24
    duck_pkg::pos_q_t  x_q_nxt, y_q_nxt;
    duck_pkg::pos_t    x_whole, y_whole;  // integer part for the edge tests
    duck_pkg::pos_t    launch_col;

    assign x_whole = x_q[35:24];
    assign y_whole = y_q[35:24];

    // registered position, whole pixels only
    assign xpos = x_whole;
    assign ypos = y_whole;

    // keep the whole duck box inside the right edge at launch
    always_comb begin : launch_blk
        if (rnd >= duck_pkg::X_MAX - duck_pkg::DUCK_WIDTH) begin
            launch_col = duck_pkg::pos_t'(rnd) - duck_pkg::pos_t'(duck_pkg::DUCK_WIDTH);
        end else begin
            launch_col = duck_pkg::pos_t'(rnd);
        end
    end

    // ------------------------------------------------------------
    // next state
    // ------------------------------------------------------------
    always_comb begin : state_comb_blk
        state_nxt = state;
        case (state)
            duck_pkg::IDLE: begin
                if (game_enable) begin
                    state_nxt = duck_pkg::SIDE;
                end
            end
            duck_pkg::SIDE: begin  // pick a side from the launch column
                if (x_whole >= duck_pkg::X_MAX / 4) begin
                    state_nxt = duck_pkg::UP_LEFT;
                end else begin
                    state_nxt = duck_pkg::UP_RIGHT;
                end
            end
            // horizontal edges are tested first in every flight state
            duck_pkg::UP_RIGHT: begin
                if (x_whole >= duck_pkg::X_MAX - duck_pkg::DUCK_WIDTH) begin
                    state_nxt = duck_pkg::UP_LEFT;
                end else if (y_whole == 0) begin  // top of screen
                    state_nxt = duck_pkg::DOWN_RIGHT;
                end
            end
            duck_pkg::UP_LEFT: begin
                if (x_whole == 0) begin  // left edge
                    state_nxt = duck_pkg::UP_RIGHT;
                end else if (y_whole == 0) begin
                    state_nxt = duck_pkg::DOWN_LEFT;
                end
            end
            duck_pkg::DOWN_RIGHT: begin
                if (x_whole >= duck_pkg::X_MAX - duck_pkg::DUCK_WIDTH) begin
                    state_nxt = duck_pkg::DOWN_LEFT;
                end else if (y_whole >= duck_pkg::GROUND - duck_pkg::DUCK_HEIGHT) begin
                    state_nxt = duck_pkg::UP_RIGHT;  // bounce off the ground line
                end
            end
            duck_pkg::DOWN_LEFT: begin
                if (x_whole == 0) begin
                    state_nxt = duck_pkg::DOWN_RIGHT;
                end else if (y_whole >= duck_pkg::GROUND - duck_pkg::DUCK_HEIGHT) begin
                    state_nxt = duck_pkg::UP_LEFT;
                end
            end
            default: state_nxt = duck_pkg::IDLE;
        endcase

        // a shot duck goes straight back to rest
        if (kill) begin
            state_nxt = duck_pkg::IDLE;
        end
    end

    // ------------------------------------------------------------
    // next position, follows the state being entered
    // ------------------------------------------------------------
    always_comb begin : pos_comb_blk
        x_q_nxt = x_q;
        y_q_nxt = y_q;
        case (state_nxt)
            duck_pkg::IDLE: begin
                x_q_nxt = {duck_pkg::pos_t'(duck_pkg::IDLE_X), 24'd0};
                y_q_nxt = {duck_pkg::pos_t'(duck_pkg::GROUND), 24'd0};
            end
            duck_pkg::SIDE: begin  // rise just above the ground line
                x_q_nxt = {launch_col, 24'd0};
                y_q_nxt = {duck_pkg::pos_t'(duck_pkg::GROUND - duck_pkg::DUCK_HEIGHT), 24'd0};
            end
            duck_pkg::UP_RIGHT: begin
                x_q_nxt = x_q + speed;
                y_q_nxt = y_q - speed;
            end
            duck_pkg::UP_LEFT: begin
                x_q_nxt = x_q - speed;
                y_q_nxt = y_q - speed;
            end
            duck_pkg::DOWN_RIGHT: begin
                x_q_nxt = x_q + speed;
                y_q_nxt = y_q + speed;
            end
            duck_pkg::DOWN_LEFT: begin
                x_q_nxt = x_q - speed;
                y_q_nxt = y_q + speed;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin : seq_blk
        if (rst) begin
            state <= duck_pkg::IDLE;
            x_q   <= {duck_pkg::pos_t'(duck_pkg::IDLE_X), 24'd0};
            y_q   <= {duck_pkg::pos_t'(duck_pkg::GROUND), 24'd0};
        end else begin
            state <= state_nxt;
            x_q   <= x_q_nxt;
            y_q   <= y_q_nxt;
        end
    end

    // the edge turns must catch the duck before it leaves the playfield
    a_x_in_range : assert property (
        @(posedge clk) disable iff (rst)
        (state != duck_pkg::IDLE) |-> (x_whole <= duck_pkg::X_MAX)
    ) else $error("duck x ran past the right limit: %0d", x_whole);

endmodule

/* duck_draw.sv */
// pixel stage, paints the duck box over the sky and re-times the syncs to match the color
`timescale 1ns/100ps

module duck_draw (
    input  logic           clk,
    input  logic           rst,
    input  duck_pkg::pos_t hcount,
    input  duck_pkg::pos_t vcount,
    input  logic           hsync_raw,
    input  logic           vsync_raw,
    input  logic           blank,
    input  duck_pkg::pos_t xpos,
    input  duck_pkg::pos_t ypos,
    output logic           hsync,
    output logic           vsync,
    output duck_pkg::rgb_t rgb
);

    logic           in_duck;  // current pixel inside the duck box
    duck_pkg::rgb_t rgb_nxt;

    // half-open box, [xpos, xpos+w) by [ypos, ypos+h)
    assign in_duck = (hcount >= xpos) && (hcount < xpos + duck_pkg::DUCK_WIDTH) &&
                     (vcount >= ypos) && (vcount < ypos + duck_pkg::DUCK_HEIGHT);

    always_comb begin : color_blk
        if (blank) begin
            rgb_nxt = '0;  // black outside the visible area
        end else if (in_duck) begin
            rgb_nxt = duck_pkg::DUCK_RGB;
        end else begin
            rgb_nxt = duck_pkg::SKY_RGB;
        end
    end

    // ------------------------------------------------------------
    // output register, syncs delayed together with the color
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin : out_blk
        if (rst) begin
            rgb   <= '0;
            hsync <= 1'b1;  // sync inactive
            vsync <= 1'b1;
        end else begin
            rgb   <= rgb_nxt;
            hsync <= hsync_raw;
            vsync <= vsync_raw;
        end
    end

endmodule

/* shot_judge.sv */
// shot judging, checks a triggered aim point against the duck box and keeps the score
`timescale 1ns/100ps

module shot_judge (
    input  logic             clk,
    input  logic             rst,
    input  logic             trigger,
    input  duck_pkg::pos_t   aim_x,
    input  duck_pkg::pos_t   aim_y,
    input  duck_pkg::pos_t   xpos,
    input  duck_pkg::pos_t   ypos,
    output logic             hit,
    output logic             kill,
    output duck_pkg::score_t score
);

    logic on_target;  // aim inside the duck box
    logic flying;     // duck is off its rest row
    logic hit_nxt;

    // same half-open rule as the pixel stage
    assign on_target = (aim_x >= xpos) && (aim_x < xpos + duck_pkg::DUCK_WIDTH) &&
                       (aim_y >= ypos) && (aim_y < ypos + duck_pkg::DUCK_HEIGHT);

    assign flying = (ypos != duck_pkg::pos_t'(duck_pkg::GROUND));

    // a strobe right after a hit would still see the dying duck, so drop it
    assign hit_nxt = trigger && !hit && flying && on_target;

    // ------------------------------------------------------------
    // hit, kill and score registers
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin : judge_blk
        if (rst) begin
            hit   <= 1'b0;
            kill  <= 1'b0;
            score <= '0;
        end else begin
            hit  <= hit_nxt;  // one clock pulse
            kill <= hit_nxt;  // sends the FSM back to rest
            if (hit_nxt && (score != '1)) begin
                score <= score + 1'b1;  // saturates at 255
            end
        end
    end

    // score moves only together with a decided hit
    a_score_on_hit : assert property (
        @(posedge clk) disable iff (rst)
        (score != $past(score)) |-> hit
    ) else $error("score changed without a hit");

endmodule

/* duck_top.sv */
// duck-hunt core top level, chains random generator, raster timing, flight, drawing and judging
`timescale 1ns/100ps

module duck_top #(
    parameter duck_pkg::pos_q_t duck_speed = duck_pkg::DUCK_SPEED_DEF  // q12.24 step
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             game_enable,
    input  logic             trigger,
    input  duck_pkg::pos_t   aim_x,
    input  duck_pkg::pos_t   aim_y,
    output logic             hsync,
    output logic             vsync,
    output duck_pkg::rgb_t   rgb,
    output duck_pkg::pos_t   xpos,
    output duck_pkg::pos_t   ypos,
    output logic             hit,
    output duck_pkg::score_t score
);

    duck_pkg::rnd_t rnd;
    duck_pkg::pos_t hcount, vcount;
    logic           hsync_raw, vsync_raw, blank;
    logic           kill;  // judge back to FSM

    lfsr_gen u_lfsr (
        .clk (clk),
        .rst (rst),
        .rnd (rnd)
    );

    vga_timing u_timing (
        .clk       (clk),
        .rst       (rst),
        .hcount    (hcount),
        .vcount    (vcount),
        .hsync_raw (hsync_raw),
        .vsync_raw (vsync_raw),
        .blank     (blank)
    );

    duck_ctl #(
        .speed (duck_speed)
    ) u_ctl (
        .clk         (clk),
        .rst         (rst),
        .game_enable (game_enable),
        .kill        (kill),
        .rnd         (rnd),
        .xpos        (xpos),
        .ypos        (ypos)
    );

    duck_draw u_draw (
        .clk       (clk),
        .rst       (rst),
        .hcount    (hcount),
        .vcount    (vcount),
        .hsync_raw (hsync_raw),
        .vsync_raw (vsync_raw),
        .blank     (blank),
        .xpos      (xpos),
        .ypos      (ypos),
        .hsync     (hsync),
        .vsync     (vsync),
        .rgb       (rgb)
    );

    shot_judge u_judge (
        .clk     (clk),
        .rst     (rst),
        .trigger (trigger),
        .aim_x   (aim_x),
        .aim_y   (aim_y),
        .xpos    (xpos),
        .ypos    (ypos),
        .hit     (hit),
        .kill    (kill),
        .score   (score)
    );

endmodule

/* duck_tb.sv */
// self-checking testbench that steps reference models of duck_top each clock and compares all outputs
`timescale 1ns/100ps

module duck_tb;

    localparam int CLK_PERIOD    = 40;
    localparam int RESET_CYCLES  = 2;
    localparam int IDLE_CYCLES   = 60;    // duck parked with the game off
    localparam int FLIGHT_CYCLES = 3000;  // free flight without shots
    localparam int SHOT_CYCLES   = 2000;  // random triggers
    localparam int FRAME_CYCLES  = duck_pkg::H_TOTAL * duck_pkg::V_TOTAL;  // one whole frame
    localparam int TOTAL_CYCLES  = RESET_CYCLES + IDLE_CYCLES + FLIGHT_CYCLES + SHOT_CYCLES +
                                   FRAME_CYCLES + 6;
    localparam duck_pkg::pos_q_t SPEED_Q = 36'h1 << 24;  // one whole pixel per clock

    logic             clk = 1'b0;
    logic             rst;
    logic             game_enable, trigger;
    duck_pkg::pos_t   aim_x, aim_y;
    logic             hsync, vsync, hit;
    duck_pkg::rgb_t   rgb;
    duck_pkg::pos_t   xpos, ypos;
    duck_pkg::score_t score;

    // ------------------------------------------------------------
    // reference model state as seen after each edge
    // ------------------------------------------------------------
    duck_pkg::flight_t m_state;
    int                m_x, m_y;          // whole pixels at a speed of exactly 1
    logic [9:0]        m_lfsr;
    int                m_h, m_v;          // raster counters
    duck_pkg::rgb_t    m_rgb;
    logic              m_hs, m_vs, m_hit;
    int                m_score;
    int                n_right = 0, n_left = 0, n_top = 0, n_ground = 0;  // bounce counts
    int                n_duck_px = 0;     // visible duck pixels drawn
    int                n_vsync_low = 0;   // clocks inside the vsync pulse
    logic              started = 1'b0;    // model valid after first reset edge
    logic [31:0]       seed;

    duck_top #(
        .duck_speed (SPEED_Q)
    ) dut (
        .clk         (clk),
        .rst         (rst),
        .game_enable (game_enable),
        .trigger     (trigger),
        .aim_x       (aim_x),
        .aim_y       (aim_y),
        .hsync       (hsync),
        .vsync       (vsync),
        .rgb         (rgb),
        .xpos        (xpos),
        .ypos        (ypos),
        .hit         (hit),
        .score       (score)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // x^10 + x^7 + 1 shifted left with feedback into bit 0
    function automatic logic [9:0] lfsr_step(input logic [9:0] v);
        return {v[8:0], v[9] ^ v[6]};
    endfunction

    function automatic logic [31:0] lcg(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] time %0t %s: got %0h, expected %0h", $time, name, got, exp);
            $display("Verification failed");
            $fatal(1, "output mismatch on %s", name);
        end
    endtask

    // ------------------------------------------------------------
    // reference models stepped on the same edge as the DUT
    // ------------------------------------------------------------
    always @(posedge clk) begin : model_blk
        duck_pkg::flight_t ns;
        int                nx, ny;
        logic              hit_n, in_duck, blank_m;
        started <= 1'b1;
        if (rst) begin
            m_state <= duck_pkg::IDLE;
            m_x     <= duck_pkg::IDLE_X;
            m_y     <= duck_pkg::GROUND;
            m_lfsr  <= 10'h001;
            m_h     <= 0;
            m_v     <= 0;
            m_rgb   <= '0;
            m_hs    <= 1'b1;
            m_vs    <= 1'b1;
            m_hit   <= 1'b0;
            m_score <= 0;
        end else begin
            ns = m_state;
            case (m_state)
                duck_pkg::IDLE: if (game_enable) ns = duck_pkg::SIDE;
                duck_pkg::SIDE: ns = (m_x >= duck_pkg::X_MAX / 4) ? duck_pkg::UP_LEFT
                                                                  : duck_pkg::UP_RIGHT;
                duck_pkg::UP_RIGHT, duck_pkg::DOWN_RIGHT: begin
                    if (m_x >= duck_pkg::X_MAX - duck_pkg::DUCK_WIDTH) begin
                        ns = (m_state == duck_pkg::UP_RIGHT) ? duck_pkg::UP_LEFT
                                                             : duck_pkg::DOWN_LEFT;
                        n_right++;
                    end else if (m_state == duck_pkg::UP_RIGHT && m_y <= 0) begin
                        ns = duck_pkg::DOWN_RIGHT;
                        n_top++;
                    end else if (m_state == duck_pkg::DOWN_RIGHT &&
                                 m_y >= duck_pkg::GROUND - duck_pkg::DUCK_HEIGHT) begin
                        ns = duck_pkg::UP_RIGHT;
                        n_ground++;
                    end
                end
                default: begin  // both left-going states
                    if (m_x <= 0) begin
                        ns = (m_state == duck_pkg::UP_LEFT) ? duck_pkg::UP_RIGHT
                                                            : duck_pkg::DOWN_RIGHT;
                        n_left++;
                    end else if (m_state == duck_pkg::UP_LEFT && m_y <= 0) begin
                        ns = duck_pkg::DOWN_LEFT;
                        n_top++;
                    end else if (m_state == duck_pkg::DOWN_LEFT &&
                                 m_y >= duck_pkg::GROUND - duck_pkg::DUCK_HEIGHT) begin
                        ns = duck_pkg::UP_LEFT;
                        n_ground++;
                    end
                end
            endcase
            if (m_hit) ns = duck_pkg::IDLE;  // kill is the same pulse as hit

            nx = m_x;
            ny = m_y;
            case (ns)
                duck_pkg::IDLE: begin
                    nx = duck_pkg::IDLE_X;
                    ny = duck_pkg::GROUND;
                end
                duck_pkg::SIDE: begin  // launch rule on the current random value
                    nx = (m_lfsr >= duck_pkg::X_MAX - duck_pkg::DUCK_WIDTH) ?
                         m_lfsr - duck_pkg::DUCK_WIDTH : m_lfsr;
                    ny = duck_pkg::GROUND - duck_pkg::DUCK_HEIGHT;
                end
                duck_pkg::UP_RIGHT: begin
                    nx = m_x + 1;
                    ny = m_y - 1;
                end
                duck_pkg::UP_LEFT: begin
                    nx = m_x - 1;
                    ny = m_y - 1;
                end
                duck_pkg::DOWN_RIGHT: begin
                    nx = m_x + 1;
                    ny = m_y + 1;
                end
                default: begin
                    nx = m_x - 1;
                    ny = m_y + 1;
                end
            endcase

            // shot scoring against the current box
            hit_n = trigger && !m_hit && (m_y != duck_pkg::GROUND) &&
                    (int'(aim_x) >= m_x) && (int'(aim_x) < m_x + duck_pkg::DUCK_WIDTH) &&
                    (int'(aim_y) >= m_y) && (int'(aim_y) < m_y + duck_pkg::DUCK_HEIGHT);

            // pixel stream from the current raster and position
            blank_m = (m_h >= duck_pkg::H_ACTIVE) || (m_v >= duck_pkg::V_ACTIVE);
            in_duck = (m_h >= m_x) && (m_h < m_x + duck_pkg::DUCK_WIDTH) &&
                      (m_v >= m_y) && (m_v < m_y + duck_pkg::DUCK_HEIGHT);
            if (!blank_m && in_duck) n_duck_px++;
            if (!m_vs) n_vsync_low++;

            m_state <= ns;
            m_x     <= nx;
            m_y     <= ny;
            m_lfsr  <= lfsr_step(m_lfsr);
            m_hit   <= hit_n;
            if (hit_n && m_score != 255) m_score <= m_score + 1;
            m_rgb <= blank_m ? 12'h000 : (in_duck ? duck_pkg::DUCK_RGB : duck_pkg::SKY_RGB);
            m_hs  <= !(m_h >= 1048 && m_h < 1048 + duck_pkg::H_SYNC);  // 1024 + 24 front porch
            m_vs  <= !(m_v >= 771 && m_v < 771 + duck_pkg::V_SYNC);    // 768 + 3 front porch
            m_h   <= (m_h == duck_pkg::H_TOTAL - 1) ? 0 : m_h + 1;
            if (m_h == duck_pkg::H_TOTAL - 1) m_v <= (m_v == duck_pkg::V_TOTAL - 1) ? 0 : m_v + 1;
        end
    end

    // outputs are settled mid-cycle
    always @(negedge clk) begin : compare_blk
        if (started) begin
            check("xpos", xpos, m_x);
            check("ypos", ypos, m_y);
            check("rgb", rgb, m_rgb);
            check("hsync", hsync, m_hs);
            check("vsync", vsync, m_vs);
            check("hit", hit, m_hit);
            check("score", score, m_score);
            if (m_state == duck_pkg::SIDE)
                check("launch ypos", ypos, 588);
        end
    end

    // ------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------
    initial begin : stim_blk
        rst         = 1'b1;
        game_enable = 1'b0;
        trigger     = 1'b0;
        aim_x       = '0;
        aim_y       = '0;
        seed        = 32'h53c2;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;

        // shots at the parked duck must never score
        repeat (IDLE_CYCLES) begin
            @(posedge clk);
            seed = lcg(seed);
            trigger <= (seed[31:30] == 2'b00);
            aim_x   <= duck_pkg::pos_t'(duck_pkg::IDLE_X + 10);
            aim_y   <= duck_pkg::pos_t'(duck_pkg::GROUND + 5);
        end

        @(posedge clk);
        trigger     <= 1'b0;
        game_enable <= 1'b1;
        repeat (FLIGHT_CYCLES - 1) @(posedge clk);

        repeat (SHOT_CYCLES) begin
            @(posedge clk);
            seed = lcg(seed);
            trigger <= (seed[31:30] == 2'b00);  // about one clock in four
            if (seed[29]) begin  // inside the box with room for one step of motion
                aim_x <= duck_pkg::pos_t'(m_x + 2 + seed[23:12] % 92);
                aim_y <= duck_pkg::pos_t'(m_y + 2 + seed[11:0] % 28);
            end else begin
                aim_x <= duck_pkg::pos_t'(seed[25:16]);
                aim_y <= duck_pkg::pos_t'(seed[15:4] % 768);
            end
        end

        @(posedge clk);
        trigger <= 1'b0;

        // a whole frame reaches the vsync pulse and the lower lines
        repeat (FRAME_CYCLES) @(posedge clk);

        repeat (4) @(posedge clk);
        if (n_right > 0 && n_left > 0 && n_top > 0 && n_ground > 0 && m_score > 0 &&
            n_duck_px > 0 && n_vsync_low > 0) begin
            $display("Verification passed");
            $finish;
        end else begin
            $display("flight missed a screen limit, no shot hit, or no duck pixel or vsync seen");
            $display("Verification failed");
            $fatal(1, "bounce, hit or raster coverage incomplete");
        end
    end

    initial begin : watchdog_blk
        #(CLK_PERIOD * (TOTAL_CYCLES + 200));
        $display("timeout, the test sequence did not complete in time");
        $display("Verification failed");
        $fatal(1, "watchdog expired");
    end

endmodule

/* sources.f */
duck_pkg.sv
lfsr_gen.sv
vga_timing.sv
duck_ctl.sv
duck_draw.sv
shot_judge.sv
duck_top.sv
duck_tb.sv
